// ==== logic/mulPkg.sv ====
package mulPkg;

    // Operand and product widths
    typedef logic signed [7:0]  operandT;
    typedef logic signed [15:0] productT;   // A above B

    // Sign bit X over the accumulator A
    typedef logic signed [8:0]  extT;

    // Index of the multiplier bit being processed
    typedef logic [2:0] stepCountT;

    typedef enum logic [2:0]
    {
        idle,
        clearAcc,
        addStep,
        shiftStep,
        done
    } ctrlStateT;

    // Bit 7 carries negative weight in two's complement
    localparam stepCountT lastStep = 3'd7;

endpackage

// ==== logic/mulCtrlIf.sv ====
`timescale 1ns/100ps

// Command bus from the sequencer to the multiplier datapath
interface mulCtrlIf;

    logic loadOperands;   // S and B take the operand inputs
    logic clearA;         // Zero X and A
    logic add;            // X:A <= A + S
    logic sub;            // X:A <= A - S
    logic shift;          // Arithmetic shift of X:A:B
    logic mBit;           // Current B[0]

    modport ctrl
    (
        output loadOperands,
        output clearA,
        output add,
        output sub,
        output shift,
        input  mBit
    );

    modport dp
    (
        input  loadOperands,
        input  clearA,
        input  add,
        input  sub,
        input  shift,
        output mBit
    );

endinterface

// ==== logic/mulControl.sv ====
`timescale 1ns/100ps

module mulControl
(
    input  logic   Clk,
    input  logic   rstN,
    input  logic   inValid,
    output logic   inReady,
    output logic   outValid,
    input  logic   outReady,
    mulCtrlIf.ctrl ctrl
);

    import mulPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    stepCountT stepCount;   // Multiplier bit under test
    logic      accept;
    logic      taken;
    logic      lastBit;

    assign inReady = (state == idle);
    assign accept  = inValid && inReady;
    assign taken   = outValid && outReady;
    assign lastBit = (stepCount == lastStep);

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state     <= idle;
            stepCount <= '0;
            outValid  <= 1'b0;
        end
        else
        begin
            state    <= nextState;
            outValid <= (nextState == done);   // Rises together with the done state
            if (state == clearAcc)
                stepCount <= '0;
            else if (state == shiftStep)
                stepCount <= stepCount + 3'd1;
        end
    end

    // Next state
    always_comb
    begin
        nextState = state;
        unique case (state)
            idle:
            begin
                if (accept)
                    nextState = clearAcc;
            end
            clearAcc:
                nextState = addStep;
            addStep:
                nextState = shiftStep;
            shiftStep:
            begin
                if (lastBit)
                    nextState = done;
                else
                    nextState = addStep;
            end
            done:
            begin
                if (taken)                  // Hold here under back-pressure
                    nextState = idle;
            end
            default:
                nextState = idle;
        endcase
    end

    // Datapath commands
    always_comb
    begin
        ctrl.loadOperands = 1'b0;
        ctrl.clearA       = 1'b0;
        ctrl.add          = 1'b0;
        ctrl.sub          = 1'b0;
        ctrl.shift        = 1'b0;
        unique case (state)
            idle:
                ctrl.loadOperands = inValid;   // Operands latch on the accepting edge
            clearAcc:
                ctrl.clearA = 1'b1;
            addStep:
            begin
                if (ctrl.mBit)
                begin
                    // Top multiplier bit has weight -128
                    if (lastBit)
                        ctrl.sub = 1'b1;
                    else
                        ctrl.add = 1'b1;
                end
            end
            shiftStep:
                ctrl.shift = 1'b1;
            default:
            begin
            end
        endcase
    end

    addSubExclusive: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(ctrl.add && ctrl.sub)
    ) else $error("add and sub asserted together");

    shiftExclusive: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(ctrl.shift && (ctrl.add || ctrl.sub))
    ) else $error("shift asserted with add or sub");

    // The flag is registered separately from the state
    validOnlyInDone: assert property (
        @(posedge Clk) disable iff (!rstN)
        outValid |-> (state == done)
    ) else $error("outValid high outside done");

endmodule

// ==== logic/mulDatapath.sv ====
`timescale 1ns/100ps

module mulDatapath
(
    input  logic            Clk,
    input  logic            rstN,
    input  mulPkg::operandT multiplicand,
    input  mulPkg::operandT multiplier,
    output mulPkg::productT product,
    mulCtrlIf.dp            dp
);

    import mulPkg::*;

    operandT regS;   // Multiplicand
    logic    regX;   // Sign above the accumulator
    operandT regA;   // Accumulator, upper product half
    operandT regB;   // Multiplier, shifts into lower product half

    extT     accExt;
    extT     addend;
    extT     sum;
    logic    addSub;

    // Both operands sign-extended to nine bits so the sum cannot overflow
    assign accExt = {regA[7], regA};
    assign addend = {regS[7], regS};
    assign addSub = dp.add || dp.sub;

    always_comb
    begin
        if (dp.sub)
            sum = accExt - addend;
        else
            sum = accExt + addend;
    end

    // Multiplicand register
    always_ff @(posedge Clk)
    begin
        if (dp.loadOperands)
            regS <= multiplicand;
    end

    // X:A:B chain
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            regX <= 1'b0;
            regA <= '0;
            regB <= '0;
        end
        else if (dp.loadOperands)
        begin
            regB <= multiplier;
        end
        else if (dp.clearA)
        begin
            regX <= 1'b0;
            regA <= '0;
        end
        else if (addSub)
        begin
            {regX, regA} <= sum;
        end
        else if (dp.shift)
        begin
            // X keeps its value and also fills A[7]
            regA <= {regX, regA[7:1]};
            regB <= {regA[0], regB[7:1]};   // Consumed multiplier bit drops out
        end
    end

    assign dp.mBit = regB[0];
    assign product = {regA, regB};

    commandOneHot: assert property (
        @(posedge Clk) disable iff (!rstN)
        $onehot0({dp.loadOperands, dp.clearA, addSub, dp.shift})
    ) else $error("overlapping datapath commands");

endmodule

// ==== logic/signedMultiplier.sv ====
`timescale 1ns/100ps

// Signed 8x8 iterative multiplier with valid/ready on both sides
module signedMultiplier
(
    input  logic            Clk,
    input  logic            rstN,

    input  logic            inValid,
    output logic            inReady,
    input  mulPkg::operandT multiplicand,
    input  mulPkg::operandT multiplier,

    output logic            outValid,
    input  logic            outReady,
    output mulPkg::productT product
);

    mulCtrlIf cmdBus ();   // Sequencer to datapath

    mulControl control_i
    (
        .Clk      (Clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .outValid (outValid),
        .outReady (outReady),
        .ctrl     (cmdBus.ctrl)
    );

    // Product is stable while outValid waits for outReady
    mulDatapath datapath_i
    (
        .Clk          (Clk),
        .rstN         (rstN),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .dp           (cmdBus.dp)
    );

endmodule

// ==== dv/multiplierTb.sv ====
`timescale 1ns/100ps

module multiplierTb;

    import mulPkg::*;

    localparam int numDirected = 5;
    localparam int numRandom   = 300;
    localparam int numPairs    = numDirected + numRandom;
    localparam int latency     = 17;
    // 305 transactions at about 45 cycles each at worst, with ample margin
    localparam int cycleLimit  = 20000;

    logic    Clk;
    logic    rstN;
    logic    inValid;
    logic    inReady;
    operandT multiplicand;
    operandT multiplier;
    logic    outValid;
    logic    outReady;
    productT product;

    logic [15:0] pairQ[$];          // Multiplicand above multiplier
    logic [15:0] acceptedPair;
    logic        acceptSeen;        // Input handshake on the last edge
    logic        takeSeen;          // Output handshake on the last edge
    logic        busy;
    logic [7:0]  edgesSinceAccept;
    logic        modelEmpty   = 1'b1;
    productT     expProduct   = '0;
    int          productCount = 0;
    int          cycleCount   = 0;

    signedMultiplier dut_i
    (
        .Clk          (Clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .outValid     (outValid),
        .outReady     (outReady),
        .product      (product)
    );

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    // Signed product of a queued pair, both halves sign-extended to 16 bits
    function automatic productT refProduct(input logic [15:0] pair);
        productT a;
        productT b;
        a = {{8{pair[15]}}, pair[15:8]};
        b = {{8{pair[7]}}, pair[7:0]};
        return a * b;
    endfunction

    function automatic operandT randomOperand();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
            failRun($sformatf("Run timed out after %0d cycles", cycleLimit));
    end

    // Handshake tracking
    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            acceptSeen       <= 1'b0;
            takeSeen         <= 1'b0;
            busy             <= 1'b0;
            edgesSinceAccept <= 8'hff;
            acceptedPair     <= '0;
        end
        else
        begin
            acceptSeen <= inValid && inReady;
            takeSeen   <= outValid && outReady;
            if (inValid && inReady)
            begin
                busy         <= 1'b1;
                acceptedPair <= {multiplicand, multiplier};
            end
            else if (outValid && outReady)
                busy <= 1'b0;
            if (inValid && inReady)
                edgesSinceAccept <= 8'd0;
            else if (!outValid && edgesSinceAccept != 8'hff)
                edgesSinceAccept <= edgesSinceAccept + 8'd1;   // Frozen once valid
        end
    end

    // Reference model, updated between edges
    always @(negedge Clk)
    begin
        if (takeSeen && pairQ.size() > 0)
        begin
            pairQ.delete(0);
            productCount = productCount + 1;
        end
        if (acceptSeen)
            pairQ.push_back(acceptedPair);
        modelEmpty = (pairQ.size() == 0);
        if (pairQ.size() > 0)
            expProduct = refProduct(pairQ[0]);
        else
            expProduct = '0;
    end

    productMatch: assert property (
        @(posedge Clk) disable iff (!rstN)
        (outValid && outReady) |-> (!modelEmpty && product == expProduct)
    ) else failRun($sformatf("FAILED at %0t: product %0d, expected %0d (model empty %0b)",
                             $time, product, expProduct, modelEmpty));

    fixedLatency: assert property (
        @(posedge Clk) disable iff (!rstN)
        $rose(outValid) |-> (edgesSinceAccept == 8'(latency))
    ) else failRun($sformatf("FAILED at %0t: outValid rose %0d edges after accept",
                             $time, edgesSinceAccept));

    holdUnderStall: assert property (
        @(posedge Clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(product))
    ) else failRun($sformatf("FAILED at %0t: output changed while stalled", $time));

    singleOccupancy: assert property (
        @(posedge Clk) disable iff (!rstN)
        inReady == !busy
    ) else failRun($sformatf("FAILED at %0t: inReady %0b while busy %0b",
                             $time, inReady, busy));

    resetState: assert property (
        @(posedge Clk)
        (!rstN || $rose(rstN)) |-> (!outValid && inReady)
    ) else failRun($sformatf("FAILED at %0t: outValid %0b inReady %0b in reset",
                             $time, outValid, inReady));

    // Called at a falling edge, returns at the falling edge after acceptance
    task automatic sendPair(input operandT a, input operandT b, input int unsigned gap);
        repeat (gap) @(negedge Clk);
        inValid      = 1'b1;
        multiplicand = a;
        multiplier   = b;
        do
            @(negedge Clk);
        while (!acceptSeen);
        inValid = 1'b0;
    endtask

    task automatic collectProduct(input int unsigned stall, input bit poke);
        do
        begin
            @(negedge Clk);
            if (poke)
            begin
                inValid      = $urandom_range(1, 0) == 1;   // Start while busy
                multiplicand = randomOperand();
                multiplier   = randomOperand();
            end
        end
        while (!outValid);
        inValid = 1'b0;
        repeat (stall) @(negedge Clk);
        outReady = 1'b1;
        do
            @(negedge Clk);
        while (!takeSeen);
        outReady = 1'b0;
    endtask

    task automatic runTransaction(input operandT a, input operandT b,
                                  input int unsigned gap, input int unsigned stall,
                                  input bit poke);
        sendPair(a, b, gap);
        collectProduct(stall, poke);
    endtask

    initial
    begin
        operandT     a;
        operandT     b;
        int unsigned gap;
        int unsigned stall;
        bit          poke;

        void'($urandom(32'hbcf75d0f));
        rstN         = 1'b1;
        inValid      = 1'b0;
        outReady     = 1'b0;
        multiplicand = '0;
        multiplier   = '0;

        #10 rstN = 1'b0;
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        @(negedge Clk);

        // Corner pairs
        runTransaction(8'sh80, 8'sh80, 0, 0, 1'b0);
        runTransaction(8'sh80, 8'sh7f, 1, 3, 1'b0);
        runTransaction(8'sh7f, 8'sh7f, 0, 5, 1'b1);
        runTransaction(8'sh00, 8'shff, 2, 0, 1'b0);
        runTransaction(8'shff, 8'shff, 0, 1, 1'b1);

        for (int i = 0; i < numRandom; i++)
        begin
            a     = randomOperand();
            b     = randomOperand();
            gap   = $urandom_range(3, 0);
            stall = $urandom_range(5, 0);
            poke  = $urandom_range(3, 0) == 0;
            runTransaction(a, b, gap, stall, poke);
        end

        repeat (2) @(posedge Clk);   // Let the model retire the last pop
        @(negedge Clk);
        if (productCount == numPairs && modelEmpty)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            failRun($sformatf("Run ended with %0d of %0d products checked",
                              productCount, numPairs));
        end
    end

endmodule

// ==== tb.f ====
logic/mulPkg.sv
logic/mulCtrlIf.sv
logic/mulControl.sv
logic/mulDatapath.sv
logic/signedMultiplier.sv
dv/multiplierTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the multiplier testbench with Verilator and run it.
# Exits non-zero unless the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module multiplierTb -f tb.f -o simMultiplier; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simMultiplier 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
